/* logic/upsp_pkg.sv */
// Shared definitions for the up-sampling input path
// Stream and pixel widths, frame size and counter width
// Beat struct passed between stream_in, upsampler and stream_out
// State encoding of the pixel-doubling FSM

`default_nettype none

package upsp_pkg;

	// Input AXI-Stream data width, only the low three bytes are RGB
	localparam int AXIS_DATA_W = 32;

	// One RGB pixel
	localparam int PIX_W = 24;

	// Largest input frame, output frame is twice as long
	localparam int FRAME_PIXELS = 8;

	// Wide enough to hold FRAME_PIXELS
	localparam int CNT_W = 4;

	// Pixel plus its end-of-frame flag
	typedef struct packed {
		logic [PIX_W-1:0] pix;
		logic             last;
	} pix_beat_t;

	// Up-sampler FSM states
	// Waiting for a pixel, then the two copies of it
	typedef enum logic [1:0] {
		UPSP_IDLE        = 2'd0,
		UPSP_EMIT_FIRST  = 2'd1,
		UPSP_EMIT_SECOND = 2'd2
	} upsp_state_e;

endpackage

`default_nettype wire

/* logic/stream_in.sv */
// AXI-Stream slave at the input of the up-sampler
// Tracks whether the current frame is closed
// Drops the unused top byte and forwards pixel plus last

`default_nettype none

module stream_in (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               start,
	input  logic                               s_axis_valid,
	input  logic [upsp_pkg::AXIS_DATA_W-1:0]   s_axis_data,
	input  logic                               s_axis_last,
	output logic                               s_axis_ready,
	output logic                               in_valid,
	output upsp_pkg::pix_beat_t                in_beat,
	input  logic                               in_ready,
	input  logic                               frame_end
);
	import upsp_pkg::*;

	// High once a frame is complete, held until the next start
	logic frame_done;
	// Beat taken from the DMA on this edge
	logic s_accept;

	assign s_accept = s_axis_valid & s_axis_ready;

	// Frame state tracking
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_done <= 1'b0;
		end else if (s_accept & s_axis_last) begin
			// DMA delivered its final beat
			frame_done <= 1'b1;
		end else if (frame_end) begin
			// Up-sampler has emitted a full frame
			frame_done <= 1'b1;
		end else if (frame_done & start) begin
			// Reopen only from the closed state
			frame_done <= 1'b0;
		end
	end

	// Hold the DMA off while the frame is closed
	assign s_axis_ready = in_ready & ~frame_done;

	// Mask valid too, so the up-sampler sees a plain valid/ready accept
	assign in_valid = s_axis_valid & ~frame_done;

	// Only the low three bytes carry RGB
	assign in_beat.pix  = s_axis_data[PIX_W-1:0];
	assign in_beat.last = s_axis_last;

endmodule

`default_nettype wire

/* logic/upsampler.sv */
// 2x horizontal nearest-neighbour up-sampler
// Latches one pixel and emits it twice
// Counts input pixels per frame and flags the frame end
// Pulses frame_end when the final output beat is taken

`default_nettype none

module upsampler (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  upsp_pkg::pix_beat_t in_beat,
	output logic                in_ready,
	output logic                up_valid,
	output upsp_pkg::pix_beat_t up_beat,
	input  logic                up_ready,
	output logic                frame_end
);
	import upsp_pkg::*;

	upsp_state_e state_q;
	upsp_state_e state_d;

	// Current pixel being doubled
	logic [PIX_W-1:0] pix_q;
	// Current pixel closes the frame
	logic             final_q;
	// Input pixels accepted in this frame
	logic [CNT_W-1:0] pix_cnt_q;

	logic in_accept;
	logic out_accept;
	logic second_copy;
	logic final_in;

	assign in_accept   = in_valid & in_ready;
	assign out_accept  = up_valid & up_ready;
	assign second_copy = (state_q == UPSP_EMIT_SECOND);

	// Incoming pixel ends the frame by flag or by count
	assign final_in = in_beat.last | (pix_cnt_q == CNT_W'(FRAME_PIXELS - 1));

	// Next state and handshake outputs
	always_comb begin
		state_d  = state_q;
		in_ready = 1'b0;
		up_valid = 1'b0;
		case (state_q)
			UPSP_IDLE: begin
				in_ready = 1'b1;
				if (in_accept) begin
					state_d = UPSP_EMIT_FIRST;
				end
			end
			UPSP_EMIT_FIRST: begin
				up_valid = 1'b1;
				if (up_ready) begin
					state_d = UPSP_EMIT_SECOND;
				end
			end
			UPSP_EMIT_SECOND: begin
				up_valid = 1'b1;
				// Take the next pixel while this copy leaves
				// Never past the end of a frame
				in_ready = up_ready & ~final_q;
				if (up_ready) begin
					if (in_accept) begin
						state_d = UPSP_EMIT_FIRST;
					end else begin
						state_d = UPSP_IDLE;
					end
				end
			end
			default: begin
				state_d = UPSP_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= UPSP_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Frame-end flag follows each latched pixel
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			final_q <= 1'b0;
		end else if (in_accept) begin
			final_q <= final_in;
		end
	end

	// Pixel counter, cleared once the frame has left
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_cnt_q <= '0;
		end else if (frame_end) begin
			pix_cnt_q <= '0;
		end else if (in_accept) begin
			pix_cnt_q <= pix_cnt_q + 1'b1;
		end
	end

	// Pixel payload
	always_ff @(posedge clk) begin
		if (in_accept) begin
			pix_q <= in_beat.pix;
		end
	end

	// Both copies carry the same pixel
	assign up_beat.pix  = pix_q;
	// last only on the second copy of the closing pixel
	assign up_beat.last = second_copy & final_q;

	assign frame_end = out_accept & second_copy & final_q;

endmodule

`default_nettype wire

/* logic/stream_out.sv */
// Output slice for the master AXI-Stream port
// Main output register plus one skid entry
// Holds data stable under back-pressure at full throughput

`default_nettype none

module stream_out (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         up_valid,
	input  upsp_pkg::pix_beat_t          up_beat,
	output logic                         up_ready,
	output logic                         m_axis_valid,
	output logic [upsp_pkg::PIX_W-1:0]   m_axis_data,
	output logic                         m_axis_last,
	input  logic                         m_axis_ready
);
	import upsp_pkg::*;

	// Entry seen on the master port
	pix_beat_t out_q;
	logic      out_valid;
	// Overflow entry while the port is stalled
	pix_beat_t skid_q;
	logic      skid_valid;

	logic up_accept;
	// Output entry free or leaving this cycle
	logic out_free;

	assign up_accept = up_valid & up_ready;
	assign out_free  = m_axis_ready | ~out_valid;

	// Only a full skid entry stalls the up-sampler
	assign up_ready = ~skid_valid;

	// Valid bits of the two entries
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
		end else if (out_free) begin
			// Skid entry drains first to keep order
			out_valid  <= skid_valid | up_valid;
			skid_valid <= 1'b0;
		end else if (up_accept) begin
			skid_valid <= 1'b1;
		end
	end

	// Beat payloads
	always_ff @(posedge clk) begin
		if (out_free) begin
			out_q <= skid_valid ? skid_q : up_beat;
		end else if (up_accept) begin
			skid_q <= up_beat;
		end
	end

	assign m_axis_valid = out_valid;
	assign m_axis_data  = out_q.pix;
	assign m_axis_last  = out_q.last;

endmodule

`default_nettype wire

/* logic/upsp_top.sv */
// Top level of the up-sampling input path
// stream_in gates the input frame
// upsampler doubles each pixel, stream_out drives the master port

`default_nettype none

module upsp_top (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             start,
	input  logic                             s_axis_valid,
	input  logic [upsp_pkg::AXIS_DATA_W-1:0] s_axis_data,
	input  logic                             s_axis_last,
	output logic                             s_axis_ready,
	output logic                             m_axis_valid,
	output logic [upsp_pkg::PIX_W-1:0]       m_axis_data,
	output logic                             m_axis_last,
	input  logic                             m_axis_ready
);
	import upsp_pkg::*;

	// stream_in to upsampler
	logic      in_valid;
	logic      in_ready;
	pix_beat_t in_beat;

	// upsampler to stream_out
	logic      up_valid;
	logic      up_ready;
	pix_beat_t up_beat;

	// Frame finished on the output side
	logic      frame_end;

	stream_in stream_in_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.s_axis_valid (s_axis_valid),
		.s_axis_data  (s_axis_data),
		.s_axis_last  (s_axis_last),
		.s_axis_ready (s_axis_ready),
		.in_valid     (in_valid),
		.in_beat      (in_beat),
		.in_ready     (in_ready),
		.frame_end    (frame_end)
	);

	upsampler upsampler_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_beat   (in_beat),
		.in_ready  (in_ready),
		.up_valid  (up_valid),
		.up_beat   (up_beat),
		.up_ready  (up_ready),
		.frame_end (frame_end)
	);

	stream_out stream_out_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.up_valid     (up_valid),
		.up_beat      (up_beat),
		.up_ready     (up_ready),
		.m_axis_valid (m_axis_valid),
		.m_axis_data  (m_axis_data),
		.m_axis_last  (m_axis_last),
		.m_axis_ready (m_axis_ready)
	);

endmodule

`default_nettype wire

/* bench/upsp_assertions.sv */
// Concurrent checks on the frame gating and the up-sampler handshake
// One checker module, bound into stream_in and into upsampler

`default_nettype none

module upsp_assertions (
	input logic                clk,
	input logic                rst_n,
	input logic                closing,
	input logic                offer_valid,
	input logic                offer_ready,
	input logic                hold_valid,
	input logic                hold_ready,
	input upsp_pkg::pix_beat_t hold_beat,
	input logic                end_pulse
);
	// Number of failed assertions
	int fail_cnt = 0;

	// Nothing crosses the input once the frame has closed
	no_xfer_closed: assert property (@(posedge clk) disable iff (!rst_n)
		closing |=> !(offer_valid && offer_ready))
	else begin
		$error("Beat transferred after the frame was closed");
		fail_cnt++;
	end

	// Held entry stays until released, payload unchanged
	hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		hold_valid && !hold_ready |=> hold_valid && $stable(hold_beat))
	else begin
		$error("Held entry changed or dropped before its release");
		fail_cnt++;
	end

	// frame_end lasts one cycle
	end_single: assert property (@(posedge clk) disable iff (!rst_n)
		end_pulse |=> !end_pulse)
	else begin
		$error("frame_end held for more than one cycle");
		fail_cnt++;
	end

endmodule

// Input side, frame closed by the DMA last beat and held until start
bind stream_in upsp_assertions stream_in_checks (
	.clk         (clk),
	.rst_n       (rst_n),
	.closing     (s_axis_valid & s_axis_ready & s_axis_last),
	.offer_valid (s_axis_valid),
	.offer_ready (s_axis_ready),
	.hold_valid  (frame_done),
	.hold_ready  (start),
	.hold_beat   ('0),
	.end_pulse   (frame_end)
);

// Up-sampler output handshake, frame closed by frame_end
bind upsampler upsp_assertions upsampler_checks (
	.clk         (clk),
	.rst_n       (rst_n),
	.closing     (frame_end),
	.offer_valid (in_valid),
	.offer_ready (in_ready),
	.hold_valid  (up_valid),
	.hold_ready  (up_ready),
	.hold_beat   (up_beat),
	.end_pulse   (frame_end)
);

`default_nettype wire

/* bench/upsp_tb.sv */
// Testbench for the up-sampling input path
// Frame table applied in a loop against a 2x doubling reference model
// Output stability, frame gating and reset checks, watchdog

`default_nettype none

module upsp_tb;
	import upsp_pkg::*;

	typedef enum logic [1:0] {
		STALL_NONE,
		STALL_ALT,
		STALL_RAND
	} stall_e;

	// Beats offered, last on the final beat, output stalls, first pixel
	typedef struct packed {
		logic [7:0]       beats;
		logic             has_last;
		stall_e           stall;
		logic [PIX_W-1:0] base;
	} frame_case_t;

	logic                   clk;
	logic                   rst_n;
	logic                   start;
	logic                   s_axis_valid;
	logic [AXIS_DATA_W-1:0] s_axis_data;
	logic                   s_axis_last;
	logic                   s_axis_ready;
	logic                   m_axis_valid;
	logic [PIX_W-1:0]       m_axis_data;
	logic                   m_axis_last;
	logic                   m_axis_ready;

	frame_case_t cases [8];
	logic        cases_ready;
	int          errors;
	int          assert_fails;

	upsp_top upsp_top_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.s_axis_valid (s_axis_valid),
		.s_axis_data  (s_axis_data),
		.s_axis_last  (s_axis_last),
		.s_axis_ready (s_axis_ready),
		.m_axis_valid (m_axis_valid),
		.m_axis_data  (m_axis_data),
		.m_axis_last  (m_axis_last),
		.m_axis_ready (m_axis_ready)
	);

	always #10 clk = ~clk;

	// Input word for beat k, top byte set so its removal shows
	function automatic logic [AXIS_DATA_W-1:0] beat_word(input logic [PIX_W-1:0] base,
			input int k);
		return {8'hc0 + 8'(k), base + 24'(k) * 24'h030507};
	endfunction

	// m_axis_ready for one cycle of a stall pattern
	function automatic logic ready_for(input stall_e stall, input int cyc);
		case (stall)
			STALL_ALT:  return cyc[0];
			STALL_RAND: return 1'($urandom());
			default:    return 1'b1;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		errors++;
		$display("Mismatch at time %0t: %s expected %0h, actual %0h", $time, name, exp, act);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error at time %0t: %s", $time, what);
	endtask

	// Offer one frame, collect and check its output, then check it stays closed
	task automatic run_frame(input frame_case_t fc, input logic reopen);
		logic [PIX_W:0]         expect_q[$];
		logic [PIX_W:0]         held;
		logic [AXIS_DATA_W-1:0] word;
		logic                   in_fire;
		logic                   was_held;
		int                     accepted;
		int                     sent;
		int                     n_out;
		int                     cyc;
		int                     k;

		// Reference: at most FRAME_PIXELS taken, each pixel twice, last on the final copy
		accepted = (fc.beats > FRAME_PIXELS) ? FRAME_PIXELS : fc.beats;
		for (k = 0; k < accepted; k++) begin
			word = beat_word(fc.base, k);
			expect_q.push_back({word[PIX_W-1:0], 1'b0});
			expect_q.push_back({word[PIX_W-1:0], k == accepted - 1});
		end
		if (reopen) begin
			@(negedge clk);
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
			if (s_axis_ready !== 1'b1)
				report_failure("s_axis_ready stayed low after the start pulse");
		end
		sent = 0;
		n_out = 0;
		cyc = 0;
		in_fire = 1'b0;
		was_held = 1'b0;
		held = '0;
		while (n_out < expect_q.size()) begin
			@(negedge clk);
			if (in_fire)
				sent++;
			// Current input beat stays offered until taken
			s_axis_valid = (sent < fc.beats);
			s_axis_data  = beat_word(fc.base, sent);
			s_axis_last  = fc.has_last && (sent == fc.beats - 1);
			in_fire = s_axis_valid && s_axis_ready;
			if (in_fire && sent >= accepted)
				report_failure("input beat accepted past the frame limit");
			if (was_held && (m_axis_valid !== 1'b1 || {m_axis_data, m_axis_last} !== held))
				report_failure("output beat changed while m_axis_ready was low");
			m_axis_ready = ready_for(fc.stall, cyc);
			if (m_axis_valid && m_axis_ready) begin
				if (m_axis_data !== expect_q[n_out][PIX_W:1])
					report_mismatch("m_axis_data", expect_q[n_out][PIX_W:1], m_axis_data);
				if (m_axis_last !== expect_q[n_out][0])
					report_mismatch("m_axis_last", expect_q[n_out][0], m_axis_last);
				n_out++;
			end
			was_held = m_axis_valid && !m_axis_ready;
			held = {m_axis_data, m_axis_last};
			cyc++;
		end
		// Closed frame for 20 cycles, an overlong frame keeps offering its next beat
		for (k = 0; k < 20; k++) begin
			@(negedge clk);
			m_axis_ready = 1'b1;
			if (s_axis_ready !== 1'b0)
				report_failure("s_axis_ready high while the frame is closed");
			if (m_axis_valid !== 1'b0)
				report_failure("extra output beat after the end of the frame");
		end
		s_axis_valid = 1'b0;
		s_axis_last  = 1'b0;
	endtask

	initial begin
		int i;

		void'($urandom(32'hc1d5));
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		s_axis_valid = 1'b0;
		s_axis_data = '0;
		s_axis_last = 1'b0;
		m_axis_ready = 1'b0;
		errors = 0;
		cases_ready = 1'b0;
		// Full, short, overlong, normal again, then the stalled runs
		cases[0] = '{8'd8, 1'b1, STALL_NONE, 24'h102030};
		cases[1] = '{8'd5, 1'b1, STALL_NONE, 24'h405060};
		cases[2] = '{8'd10, 1'b0, STALL_NONE, 24'h708090};
		cases[3] = '{8'd8, 1'b1, STALL_NONE, 24'ha0b0c0};
		cases[4] = '{8'd8, 1'b1, STALL_ALT, 24'h0a0b0c};
		cases[5] = '{8'd8, 1'b1, STALL_RAND, 24'h112233};
		cases[6] = '{8'd5, 1'b1, STALL_RAND, 24'h445566};
		cases[7] = '{8'd10, 1'b0, STALL_ALT, 24'h778899};
		cases_ready = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// Open frame straight out of reset, no start needed
		@(negedge clk);
		if (m_axis_valid !== 1'b0)
			report_failure("m_axis_valid high after reset");
		if (s_axis_ready !== 1'b1)
			report_failure("s_axis_ready low after reset");
		for (i = 0; i < $size(cases); i++)
			run_frame(cases[i], i > 0);
		assert_fails = upsp_top_inst.stream_in_inst.stream_in_checks.fail_cnt
			+ upsp_top_inst.upsampler_inst.upsampler_checks.fail_cnt;
		$display("Errors: %0d testbench checks, %0d assertions", errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Watchdog, 40 cycles per offered beat plus reset, start and hold cycles
	initial begin
		longint limit;
		int     total_beats;
		int     k;

		wait (cases_ready === 1'b1);
		total_beats = 0;
		for (k = 0; k < $size(cases); k++)
			total_beats += cases[k].beats;
		limit = (total_beats * 40 + $size(cases) * 30 + 100) * 20;
		#(limit);
		$display("Timeout: run did not finish within %0d time units", limit);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
logic/upsp_pkg.sv
logic/stream_in.sv
logic/upsampler.sv
logic/stream_out.sv
logic/upsp_top.sv
bench/upsp_assertions.sv
bench/upsp_tb.sv
